// ==== common/vint_pkg.sv ====
// vector integer lane shared definitions
// element widths, opcode encodings and unit selection types

package vint_pkg;

    // ==================================================
    // widths and pipeline shape
    // ==================================================
    localparam int DATA_W             = 32;
    localparam int FUNCT6_W           = 6;
    // 32-bit operand times one byte
    localparam int PART_W             = DATA_W + 8;
    localparam int DIV_STAGES         = 4;
    localparam int DIV_BITS_PER_STAGE = 8;

    // cycles from accepting edge to result
    localparam int MUL_LATENCY        = 3;
    localparam int DIV_LATENCY        = 4;
    localparam int ALU_LATENCY        = 1;

    typedef logic [DATA_W-1:0]   elem_t;
    typedef logic [2*DATA_W-1:0] wide_t;
    typedef logic [PART_W-1:0]   part_t;
    typedef logic [FUNCT6_W-1:0] funct6_t;

    // ==================================================
    // funct6 encodings
    // ==================================================
    // add, sub and logic
    localparam funct6_t FUNCT6_VADD    = 6'b000000;
    localparam funct6_t FUNCT6_VSUB    = 6'b000010;
    localparam funct6_t FUNCT6_VRSUB   = 6'b000011;
    localparam funct6_t FUNCT6_VAND    = 6'b001001;
    localparam funct6_t FUNCT6_VOR     = 6'b001010;
    localparam funct6_t FUNCT6_VXOR    = 6'b001011;

    // divide and remainder
    localparam funct6_t FUNCT6_VDIVU   = 6'b100000;
    localparam funct6_t FUNCT6_VDIV    = 6'b100001;
    localparam funct6_t FUNCT6_VREMU   = 6'b100010;
    localparam funct6_t FUNCT6_VREM    = 6'b100011;

    // multiply
    localparam funct6_t FUNCT6_VMULHU  = 6'b100100;
    localparam funct6_t FUNCT6_VMUL    = 6'b100101;
    localparam funct6_t FUNCT6_VMULHSU = 6'b100110;
    localparam funct6_t FUNCT6_VMULH   = 6'b100111;

    // ==================================================
    // operation and unit selects
    // ==================================================
    typedef enum logic [2:0] {
        ADD,
        SUB,
        RSUB,
        AND,
        OR,
        XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        ALU,
        MUL,
        DIV
    } unit_e;

endpackage

// ==== div/vint_div.sv ====
// four-stage pipelined divider for quotient and remainder
// unsigned core on magnitudes, signs restored after the last stage

`timescale 1ns/1ns

module vint_div import vint_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  go_i,
    input  logic  signed_i,
    input  logic  want_rem_i,
    input  elem_t op_a_i,
    input  elem_t op_b_i,
    input  logic  mask_i,
    output logic  valid_o,
    output elem_t result_o
);

    logic  a_neg;
    logic  b_neg;
    elem_t mag_a;
    elem_t mag_b;

    // index 0 is the prepared input, index s+1 is stage s output
    logic [DIV_STAGES:0] valid_w;
    logic [DIV_STAGES:0] neg_quot_w;
    logic [DIV_STAGES:0] neg_rem_w;
    logic [DIV_STAGES:0] want_rem_w;
    logic [DIV_STAGES:0] mask_w;
    elem_t               quot_w    [DIV_STAGES+1];
    elem_t               rem_w     [DIV_STAGES+1];
    elem_t               divisor_w [DIV_STAGES+1];

    elem_t quot_fix;
    elem_t rem_fix;

    // ==================================================
    // operand preparation
    // ==================================================
    assign a_neg = signed_i & op_a_i[DATA_W-1];
    assign b_neg = signed_i & op_b_i[DATA_W-1];
    assign mag_a = a_neg ? (~op_a_i + 1'b1) : op_a_i;
    assign mag_b = b_neg ? (~op_b_i + 1'b1) : op_b_i;

    assign valid_w[0]    = go_i;
    assign quot_w[0]     = mag_a;
    assign rem_w[0]      = '0;
    assign divisor_w[0]  = mag_b;
    // truncated division, remainder takes the dividend sign
    assign neg_quot_w[0] = a_neg ^ b_neg;
    assign neg_rem_w[0]  = a_neg;
    assign want_rem_w[0] = want_rem_i;
    assign mask_w[0]     = mask_i;

    // ==================================================
    // division pipeline
    // ==================================================
    for (genvar s = 0; s < DIV_STAGES; s++) begin : g_stage
        vint_div_stage u_stage (
            .clk        (clk),
            .rst_n      (rst_n),
            .valid_i    (valid_w[s]),
            .quot_i     (quot_w[s]),
            .rem_i      (rem_w[s]),
            .divisor_i  (divisor_w[s]),
            .neg_quot_i (neg_quot_w[s]),
            .neg_rem_i  (neg_rem_w[s]),
            .want_rem_i (want_rem_w[s]),
            .mask_i     (mask_w[s]),
            .valid_o    (valid_w[s+1]),
            .quot_o     (quot_w[s+1]),
            .rem_o      (rem_w[s+1]),
            .divisor_o  (divisor_w[s+1]),
            .neg_quot_o (neg_quot_w[s+1]),
            .neg_rem_o  (neg_rem_w[s+1]),
            .want_rem_o (want_rem_w[s+1]),
            .mask_o     (mask_w[s+1])
        );
    end

    // ==================================================
    // sign fix and result select
    // ==================================================
    assign quot_fix = neg_quot_w[DIV_STAGES] ? (~quot_w[DIV_STAGES] + 1'b1)
                                             : quot_w[DIV_STAGES];
    assign rem_fix  = neg_rem_w[DIV_STAGES] ? (~rem_w[DIV_STAGES] + 1'b1)
                                            : rem_w[DIV_STAGES];

    assign result_o = !mask_w[DIV_STAGES]    ? '0      :
                      want_rem_w[DIV_STAGES] ? rem_fix : quot_fix;
    assign valid_o  = valid_w[DIV_STAGES];

endmodule

// ==== div/vint_div_stage.sv ====
// one pipelined division step group
// resolves 8 quotient bits by shift and subtract, then registers

`timescale 1ns/1ns

module vint_div_stage import vint_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  valid_i,
    input  elem_t quot_i,
    input  elem_t rem_i,
    input  elem_t divisor_i,
    input  logic  neg_quot_i,
    input  logic  neg_rem_i,
    input  logic  want_rem_i,
    input  logic  mask_i,
    output logic  valid_o,
    output elem_t quot_o,
    output elem_t rem_o,
    output elem_t divisor_o,
    output logic  neg_quot_o,
    output logic  neg_rem_o,
    output logic  want_rem_o,
    output logic  mask_o
);

    elem_t q_next;
    elem_t r_next;

    // quot holds the dividend bits not yet consumed in its upper end,
    // and the new quotient bits fill in from the bottom
    always_comb begin : step_loop
        logic [DATA_W:0]   shifted;
        logic [DATA_W+1:0] diff;
        q_next = quot_i;
        r_next = rem_i;
        for (int i = 0; i < DIV_BITS_PER_STAGE; i++) begin
            // 33 bits so a divisor above 2^31 cannot overflow
            shifted = {r_next, q_next[DATA_W-1]};
            q_next  = {q_next[DATA_W-2:0], 1'b0};
            diff    = {1'b0, shifted} - {2'b00, divisor_i};
            if (!diff[DATA_W+1]) begin
                r_next    = diff[DATA_W-1:0];
                q_next[0] = 1'b1;
            end else begin
                r_next = shifted[DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            quot_o     <= q_next;
            rem_o      <= r_next;
            divisor_o  <= divisor_i;
            neg_quot_o <= neg_quot_i;
            neg_rem_o  <= neg_rem_i;
            want_rem_o <= want_rem_i;
            mask_o     <= mask_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule

// ==== mul/vint_mul.sv ====
// three-stage 32x32 multiplier built from byte partial products
// magnitude multiply, then sign fix and low or high word select

`timescale 1ns/1ns

module vint_mul import vint_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  go_i,
    input  logic  a_signed_i,
    input  logic  b_signed_i,
    input  logic  upper_half_i,
    input  elem_t op_a_i,
    input  elem_t op_b_i,
    input  logic  mask_i,
    output logic  valid_o,
    output elem_t result_o
);

    logic  a_neg;
    logic  b_neg;
    elem_t mag_a;
    elem_t mag_b;

    logic  valid_s1;
    part_t parts_s1 [4];
    logic  neg_s1;
    logic  upper_s1;
    logic  mask_s1;

    logic  valid_s2;
    wide_t sum_s2;
    logic  neg_s2;
    logic  upper_s2;
    logic  mask_s2;

    wide_t product;

    // ==================================================
    // stage 1: magnitudes and byte partial products
    // ==================================================
    // only a negative signed operand is negated
    assign a_neg = a_signed_i & op_a_i[DATA_W-1];
    assign b_neg = b_signed_i & op_b_i[DATA_W-1];
    assign mag_a = a_neg ? (~op_a_i + 1'b1) : op_a_i;
    assign mag_b = b_neg ? (~op_b_i + 1'b1) : op_b_i;

    always_ff @(posedge clk) begin
        if (go_i) begin
            for (int k = 0; k < 4; k++) begin
                parts_s1[k] <= mag_a * mag_b[8*k +: 8];
            end
            neg_s1   <= a_neg ^ b_neg;
            upper_s1 <= upper_half_i;
            mask_s1  <= mask_i;
        end
    end

    // ==================================================
    // stage 2: shifted sum of the four parts
    // ==================================================
    always_ff @(posedge clk) begin
        if (valid_s1) begin
            sum_s2   <= wide_t'(parts_s1[0])
                      + (wide_t'(parts_s1[1]) << 8)
                      + (wide_t'(parts_s1[2]) << 16)
                      + (wide_t'(parts_s1[3]) << 24);
            neg_s2   <= neg_s1;
            upper_s2 <= upper_s1;
            mask_s2  <= mask_s1;
        end
    end

    // ==================================================
    // stage 3: sign fix, half select, mask
    // ==================================================
    assign product = neg_s2 ? (~sum_s2 + 1'b1) : sum_s2;

    always_ff @(posedge clk) begin
        if (valid_s2) begin
            if (!mask_s2) begin
                result_o <= '0;
            end else if (upper_s2) begin
                result_o <= product[DATA_W +: DATA_W];
            end else begin
                result_o <= product[0 +: DATA_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_s1 <= go_i;
            valid_s2 <= valid_s1;
            valid_o  <= valid_s2;
        end
    end

    valid_known_a : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_o))
        else $error("multiplier valid is unknown");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the lane testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_vint_unit -o sim_vint

out=$(./obj_dir/sim_vint || true)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== src.f ====
+incdir+test
common/vint_pkg.sv
verilog/vint_decode.sv
verilog/vint_logic_alu.sv
mul/vint_mul.sv
div/vint_div_stage.sv
div/vint_div.sv
verilog/vint_unit_top.sv
test/tb_vint_unit.sv

// ==== test/vint_ref_model.svh ====
// expected results for the vector integer lane
// plain arithmetic on the operation rules, one function per unit

`ifndef VINT_REF_MODEL_SVH
`define VINT_REF_MODEL_SVH

// which unit answers an opcode, NONE for unknown codes
function automatic unit_e unit_of(input funct6_t f);
    case (f)
        FUNCT6_VADD, FUNCT6_VSUB, FUNCT6_VRSUB,
        FUNCT6_VAND, FUNCT6_VOR, FUNCT6_VXOR   : return ALU;
        FUNCT6_VMUL, FUNCT6_VMULH,
        FUNCT6_VMULHSU, FUNCT6_VMULHU          : return MUL;
        FUNCT6_VDIV, FUNCT6_VDIVU,
        FUNCT6_VREM, FUNCT6_VREMU              : return DIV;
        default                                : return NONE;
    endcase
endfunction

// vsub is b minus a, vrsub is a minus b
function automatic elem_t alu_ref(input funct6_t f, input elem_t a, input elem_t b);
    case (f)
        FUNCT6_VADD  : return a + b;
        FUNCT6_VSUB  : return b - a;
        FUNCT6_VRSUB : return a - b;
        FUNCT6_VAND  : return a & b;
        FUNCT6_VOR   : return a | b;
        default      : return a ^ b;
    endcase
endfunction

// 64-bit products of the sign or zero extended operands
function automatic elem_t mul_ref(input funct6_t f, input elem_t a, input elem_t b);
    logic [63:0] sext_a;
    logic [63:0] sext_b;
    logic [63:0] zext_a;
    logic [63:0] zext_b;
    logic [63:0] prod;
    sext_a = {{32{a[31]}}, a};
    sext_b = {{32{b[31]}}, b};
    zext_a = {32'b0, a};
    zext_b = {32'b0, b};
    case (f)
        FUNCT6_VMUL, FUNCT6_VMULH : prod = sext_a * sext_b;
        FUNCT6_VMULHSU            : prod = sext_a * zext_b;
        default                   : prod = zext_a * zext_b;
    endcase
    return (f == FUNCT6_VMUL) ? prod[31:0] : prod[63:32];
endfunction

// truncating division, remainder keeps the dividend sign
function automatic elem_t div_ref(input funct6_t f, input elem_t a, input elem_t b);
    case (f)
        FUNCT6_VDIVU : return a / b;
        FUNCT6_VREMU : return a % b;
        FUNCT6_VDIV  : return elem_t'($signed(a) / $signed(b));
        default      : return elem_t'($signed(a) % $signed(b));
    endcase
endfunction

function automatic elem_t expect_result(input funct6_t f, input elem_t a, input elem_t b,
                                        input logic m);
    if (!m) begin
        return '0;
    end
    case (unit_of(f))
        ALU     : return alu_ref(f, a, b);
        MUL     : return mul_ref(f, a, b);
        DIV     : return div_ref(f, a, b);
        default : return '0;
    endcase
endfunction

`endif

// ==== test/tb_vint_unit.sv ====
// testbench for the vector integer lane
// random and corner stimulus, per-unit result queues checked by assertions

`timescale 1ns/1ns

module tb_vint_unit import vint_pkg::*; ();

    `include "vint_ref_model.svh"

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 8;
    localparam int ROUNDS       = 8;
    localparam int MIX_OPS      = 80;
    localparam int DIRECTED     = 9;
    localparam int TOTAL_OPS    = 14 * ROUNDS + DIRECTED + MIX_OPS + 14 + 4;

    // alu codes first, then multiply, then divide
    localparam funct6_t KNOWN_OPS [14] = '{
        FUNCT6_VADD, FUNCT6_VSUB, FUNCT6_VRSUB, FUNCT6_VAND, FUNCT6_VOR, FUNCT6_VXOR,
        FUNCT6_VMUL, FUNCT6_VMULH, FUNCT6_VMULHSU, FUNCT6_VMULHU,
        FUNCT6_VDIV, FUNCT6_VDIVU, FUNCT6_VREM, FUNCT6_VREMU
    };
    localparam funct6_t UNKNOWN_OPS [4] = '{6'b000001, 6'b000100, 6'b010000, 6'b111111};
    localparam elem_t CORNERS [7] = '{
        32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
        32'h7fff_ffff, 32'h0001_0000, 32'hffff_fffe
    };

    logic    clk;
    logic    rst_n;
    logic    valid_i;
    funct6_t funct6_i;
    elem_t   op_a_i;
    elem_t   op_b_i;
    logic    mask_i;
    logic    alu_valid_o;
    elem_t   alu_result_o;
    logic    mul_valid_o;
    elem_t   mul_result_o;
    logic    div_valid_o;
    elem_t   div_result_o;

    int seed        = 5686;
    int edge_cnt    = 0;
    int value_errs  = 0;
    int strobe_errs = 0;
    int missing     = 0;

    // expected results waiting for their due edge
    int    alu_due_q [$];
    elem_t alu_data_q [$];
    string alu_name_q [$];
    int    mul_due_q [$];
    elem_t mul_data_q [$];
    string mul_name_q [$];
    int    div_due_q [$];
    elem_t div_data_q [$];
    string div_name_q [$];

    // what the next rising edge should show
    logic  exp_alu_valid = 1'b0;
    elem_t exp_alu_data  = '0;
    string exp_alu_name  = "";
    logic  exp_mul_valid = 1'b0;
    elem_t exp_mul_data  = '0;
    string exp_mul_name  = "";
    logic  exp_div_valid = 1'b0;
    elem_t exp_div_data  = '0;
    string exp_div_name  = "";

    vint_unit_top u_vint_unit_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .funct6_i     (funct6_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .mask_i       (mask_i),
        .alu_valid_o  (alu_valid_o),
        .alu_result_o (alu_result_o),
        .mul_valid_o  (mul_valid_o),
        .mul_result_o (mul_result_o),
        .div_valid_o  (div_valid_o),
        .div_result_o (div_result_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic string op_name(input funct6_t f);
        case (f)
            FUNCT6_VADD    : return "vadd";
            FUNCT6_VSUB    : return "vsub";
            FUNCT6_VRSUB   : return "vrsub";
            FUNCT6_VAND    : return "vand";
            FUNCT6_VOR     : return "vor";
            FUNCT6_VXOR    : return "vxor";
            FUNCT6_VMUL    : return "vmul";
            FUNCT6_VMULH   : return "vmulh";
            FUNCT6_VMULHSU : return "vmulhsu";
            FUNCT6_VMULHU  : return "vmulhu";
            FUNCT6_VDIV    : return "vdiv";
            FUNCT6_VDIVU   : return "vdivu";
            FUNCT6_VREM    : return "vrem";
            FUNCT6_VREMU   : return "vremu";
            default        : return "unknown";
        endcase
    endfunction

    // mostly random, now and then a corner value
    task automatic pick_operand(output elem_t v);
        int r;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            v = CORNERS[$unsigned($random(seed)) % 7];
        end else begin
            v = $random(seed);
        end
    endtask

    // keeps divides away from zero divisors and signed overflow
    task automatic fix_divisor(input funct6_t f, input elem_t a, inout elem_t b);
        if (unit_of(f) == DIV) begin
            if (b == '0) begin
                b = 32'd7;
            end
            if ((f == FUNCT6_VDIV || f == FUNCT6_VREM) && a == 32'h8000_0000
                && b == 32'hffff_ffff) begin
                b = 32'd3;
            end
        end
    endtask

    // drives one operation for one cycle and queues its result
    task automatic issue_op(input funct6_t f, input elem_t a, input elem_t b,
                            input logic m, input string group);
        elem_t exp;
        string name;
        name     = {group, "/", op_name(f)};
        exp      = expect_result(f, a, b, m);
        valid_i  = 1'b1;
        funct6_i = f;
        op_a_i   = a;
        op_b_i   = b;
        mask_i   = m;
        // accepted on the next edge, edge_cnt + 1
        case (unit_of(f))
            ALU : begin
                alu_due_q.push_back(edge_cnt + 1 + ALU_LATENCY);
                alu_data_q.push_back(exp);
                alu_name_q.push_back(name);
            end
            MUL : begin
                mul_due_q.push_back(edge_cnt + 1 + MUL_LATENCY);
                mul_data_q.push_back(exp);
                mul_name_q.push_back(name);
            end
            DIV : begin
                div_due_q.push_back(edge_cnt + 1 + DIV_LATENCY);
                div_data_q.push_back(exp);
                div_name_q.push_back(name);
            end
            default : begin
            end
        endcase
        @(posedge clk);
        #2;
    endtask

    task automatic issue_random(input funct6_t f, input logic m, input string group);
        elem_t a;
        elem_t b;
        pick_operand(a);
        pick_operand(b);
        fix_divisor(f, a, b);
        issue_op(f, a, b, m, group);
    endtask

    // ==================================================
    // expectations for the coming edge
    // ==================================================
    always @(negedge clk) begin
        exp_alu_valid = 1'b0;
        if (alu_due_q.size() > 0 && alu_due_q[0] == edge_cnt + 1) begin
            exp_alu_valid = 1'b1;
            exp_alu_data  = alu_data_q.pop_front();
            exp_alu_name  = alu_name_q.pop_front();
            void'(alu_due_q.pop_front());
        end
        exp_mul_valid = 1'b0;
        if (mul_due_q.size() > 0 && mul_due_q[0] == edge_cnt + 1) begin
            exp_mul_valid = 1'b1;
            exp_mul_data  = mul_data_q.pop_front();
            exp_mul_name  = mul_name_q.pop_front();
            void'(mul_due_q.pop_front());
        end
        exp_div_valid = 1'b0;
        if (div_due_q.size() > 0 && div_due_q[0] == edge_cnt + 1) begin
            exp_div_valid = 1'b1;
            exp_div_data  = div_data_q.pop_front();
            exp_div_name  = div_name_q.pop_front();
            void'(div_due_q.pop_front());
        end
    end

    // ==================================================
    // checks
    // ==================================================
    alu_strobe_a : assert property (@(posedge clk) disable iff (!rst_n)
        alu_valid_o == exp_alu_valid)
        else begin
            strobe_errs++;
            if (exp_alu_valid)
                $display("alu result for %s did not arrive on time", exp_alu_name);
            else
                $display("alu raised a valid strobe with no operation due");
        end

    alu_data_a : assert property (@(posedge clk) disable iff (!rst_n)
        (exp_alu_valid && alu_valid_o) |-> alu_result_o == exp_alu_data)
        else begin
            value_errs++;
            $display("ERR %s expected %h actual %h", exp_alu_name, exp_alu_data,
                     $sampled(alu_result_o));
        end

    mul_strobe_a : assert property (@(posedge clk) disable iff (!rst_n)
        mul_valid_o == exp_mul_valid)
        else begin
            strobe_errs++;
            if (exp_mul_valid)
                $display("multiplier result for %s did not arrive on time", exp_mul_name);
            else
                $display("multiplier raised a valid strobe with no operation due");
        end

    mul_data_a : assert property (@(posedge clk) disable iff (!rst_n)
        (exp_mul_valid && mul_valid_o) |-> mul_result_o == exp_mul_data)
        else begin
            value_errs++;
            $display("ERR %s expected %h actual %h", exp_mul_name, exp_mul_data,
                     $sampled(mul_result_o));
        end

    div_strobe_a : assert property (@(posedge clk) disable iff (!rst_n)
        div_valid_o == exp_div_valid)
        else begin
            strobe_errs++;
            if (exp_div_valid)
                $display("divider result for %s did not arrive on time", exp_div_name);
            else
                $display("divider raised a valid strobe with no operation due");
        end

    div_data_a : assert property (@(posedge clk) disable iff (!rst_n)
        (exp_div_valid && div_valid_o) |-> div_result_o == exp_div_data)
        else begin
            value_errs++;
            $display("ERR %s expected %h actual %h", exp_div_name, exp_div_data,
                     $sampled(div_result_o));
        end

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        valid_i  = 1'b0;
        funct6_i = '0;
        op_a_i   = '0;
        op_b_i   = '0;
        mask_i   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // idle after reset, no strobes expected
        repeat (4) @(posedge clk);
        #2;

        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 0; k < 6; k++) begin
                issue_random(KNOWN_OPS[k], 1'b1, "alu");
            end
        end

        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 6; k < 10; k++) begin
                issue_random(KNOWN_OPS[k], 1'b1, "mul");
            end
        end
        // negative by negative and signed a against unsigned b
        issue_op(FUNCT6_VMUL, 32'hffff_ff9c, 32'hffff_fff9, 1'b1, "mul_dir");
        issue_op(FUNCT6_VMULH, 32'hffff_ff9c, 32'hffff_fff9, 1'b1, "mul_dir");
        issue_op(FUNCT6_VMULH, 32'h8000_0000, 32'h8000_0000, 1'b1, "mul_dir");
        issue_op(FUNCT6_VMULHSU, 32'h8000_0000, 32'hffff_ffff, 1'b1, "mul_dir");
        issue_op(FUNCT6_VMULHSU, 32'hffff_fffe, 32'h0000_0003, 1'b1, "mul_dir");

        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 10; k < 14; k++) begin
                issue_random(KNOWN_OPS[k], 1'b1, "div");
            end
        end
        issue_op(FUNCT6_VDIV, 32'hffff_fff9, 32'h0000_0002, 1'b1, "div_dir");
        issue_op(FUNCT6_VREM, 32'hffff_fff9, 32'h0000_0002, 1'b1, "div_dir");
        issue_op(FUNCT6_VREM, 32'h0000_0007, 32'hffff_fffe, 1'b1, "div_dir");
        issue_op(FUNCT6_VDIVU, 32'hffff_ffff, 32'h8000_0001, 1'b1, "div_dir");

        // every cycle, all units mixed, with some unknown codes
        for (int n = 0; n < MIX_OPS; n++) begin
            int pick;
            pick = $unsigned($random(seed)) % 16;
            if (pick >= 14) begin
                issue_random(UNKNOWN_OPS[pick - 14], 1'b1, "mix");
            end else begin
                issue_random(KNOWN_OPS[pick], 1'b1, "mix");
            end
        end

        for (int k = 0; k < 14; k++) begin
            issue_random(KNOWN_OPS[k], 1'b0, "masked");
        end
        for (int k = 0; k < 4; k++) begin
            issue_random(UNKNOWN_OPS[k], 1'b1, "unknown");
        end

        valid_i = 1'b0;
        repeat (DIV_LATENCY + 4) @(posedge clk);
        #2;
        missing = alu_due_q.size() + mul_due_q.size() + div_due_q.size();
        if (missing != 0) begin
            $display("%0d expected results were never checked", missing);
        end
        $display("errors: value %0d, strobe %0d, missing %0d",
                 value_errs, strobe_errs, missing);
        if (value_errs + strobe_errs + missing == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // one cycle per issued op plus reset and drain margin
    initial begin
        #((TOTAL_OPS + RESET_CYCLES + 20) * PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verilog/vint_decode.sv ====
// opcode decoder for the vector integer lane
// picks the execution unit and its operation flags from funct6

`timescale 1ns/1ns

module vint_decode import vint_pkg::*; (
    input  funct6_t funct6_i,
    input  logic    valid_i,
    output logic    alu_go_o,
    output logic    mul_go_o,
    output logic    div_go_o,
    output alu_op_e alu_op_o,
    output logic    a_signed_o,
    output logic    b_signed_o,
    output logic    upper_half_o,
    output logic    div_signed_o,
    output logic    want_rem_o
);

    unit_e unit;

    always_comb begin
        unit         = NONE;
        alu_op_o     = ADD;
        a_signed_o   = 1'b0;
        b_signed_o   = 1'b0;
        upper_half_o = 1'b0;
        div_signed_o = 1'b0;
        want_rem_o   = 1'b0;
        case (funct6_i)
            FUNCT6_VADD  : begin
                unit     = ALU;
                alu_op_o = ADD;
            end
            FUNCT6_VSUB  : begin
                unit     = ALU;
                alu_op_o = SUB;
            end
            FUNCT6_VRSUB : begin
                unit     = ALU;
                alu_op_o = RSUB;
            end
            FUNCT6_VAND  : begin
                unit     = ALU;
                alu_op_o = AND;
            end
            FUNCT6_VOR   : begin
                unit     = ALU;
                alu_op_o = OR;
            end
            FUNCT6_VXOR  : begin
                unit     = ALU;
                alu_op_o = XOR;
            end
            // low word is the same for any signedness
            FUNCT6_VMUL  : begin
                unit       = MUL;
                a_signed_o = 1'b1;
                b_signed_o = 1'b1;
            end
            FUNCT6_VMULH : begin
                unit         = MUL;
                a_signed_o   = 1'b1;
                b_signed_o   = 1'b1;
                upper_half_o = 1'b1;
            end
            FUNCT6_VMULHSU : begin
                unit         = MUL;
                a_signed_o   = 1'b1;
                upper_half_o = 1'b1;
            end
            FUNCT6_VMULHU : begin
                unit         = MUL;
                upper_half_o = 1'b1;
            end
            FUNCT6_VDIVU : begin
                unit = DIV;
            end
            FUNCT6_VDIV  : begin
                unit         = DIV;
                div_signed_o = 1'b1;
            end
            FUNCT6_VREMU : begin
                unit       = DIV;
                want_rem_o = 1'b1;
            end
            FUNCT6_VREM  : begin
                unit         = DIV;
                div_signed_o = 1'b1;
                want_rem_o   = 1'b1;
            end
            default : begin
                unit = NONE;
            end
        endcase
    end

    // unknown opcodes fall through to NONE and raise nothing
    assign alu_go_o = valid_i && (unit == ALU);
    assign mul_go_o = valid_i && (unit == MUL);
    assign div_go_o = valid_i && (unit == DIV);

    // the three units share operands, so only one may take them
    always_comb begin
        assert ($isunknown({alu_go_o, mul_go_o, div_go_o}) ||
                $onehot0({alu_go_o, mul_go_o, div_go_o}))
            else $error("decode raised more than one unit strobe");
    end

endmodule

// ==== verilog/vint_logic_alu.sv ====
// single-cycle add, subtract and bitwise logic unit
// masked-off elements still return a valid zero result

`timescale 1ns/1ns

module vint_logic_alu import vint_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    go_i,
    input  alu_op_e op_i,
    input  elem_t   op_a_i,
    input  elem_t   op_b_i,
    input  logic    mask_i,
    output logic    valid_o,
    output elem_t   result_o
);

    elem_t alu_res;

    // vsub is b minus a, vrsub is a minus b
    always_comb begin
        case (op_i)
            ADD     : alu_res = op_a_i + op_b_i;
            SUB     : alu_res = op_b_i - op_a_i;
            RSUB    : alu_res = op_a_i - op_b_i;
            AND     : alu_res = op_a_i & op_b_i;
            OR      : alu_res = op_a_i | op_b_i;
            XOR     : alu_res = op_a_i ^ op_b_i;
            default : alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (go_i) begin
            result_o <= mask_i ? alu_res : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= go_i;
        end
    end

endmodule

// ==== verilog/vint_unit_top.sv ====
// one element lane of the vector integer execution unit
// decoder feeding the logic unit, multiplier and divider

`timescale 1ns/1ns

module vint_unit_top import vint_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    valid_i,
    input  funct6_t funct6_i,
    input  elem_t   op_a_i,
    input  elem_t   op_b_i,
    input  logic    mask_i,
    output logic    alu_valid_o,
    output elem_t   alu_result_o,
    output logic    mul_valid_o,
    output elem_t   mul_result_o,
    output logic    div_valid_o,
    output elem_t   div_result_o
);

    logic    alu_go;
    logic    mul_go;
    logic    div_go;
    alu_op_e alu_op;
    logic    a_signed;
    logic    b_signed;
    logic    upper_half;
    logic    div_signed;
    logic    want_rem;

    vint_decode u_decode (
        .funct6_i     (funct6_i),
        .valid_i      (valid_i),
        .alu_go_o     (alu_go),
        .mul_go_o     (mul_go),
        .div_go_o     (div_go),
        .alu_op_o     (alu_op),
        .a_signed_o   (a_signed),
        .b_signed_o   (b_signed),
        .upper_half_o (upper_half),
        .div_signed_o (div_signed),
        .want_rem_o   (want_rem)
    );

    vint_logic_alu u_logic_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .go_i     (alu_go),
        .op_i     (alu_op),
        .op_a_i   (op_a_i),
        .op_b_i   (op_b_i),
        .mask_i   (mask_i),
        .valid_o  (alu_valid_o),
        .result_o (alu_result_o)
    );

    vint_mul u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .go_i         (mul_go),
        .a_signed_i   (a_signed),
        .b_signed_i   (b_signed),
        .upper_half_i (upper_half),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .mask_i       (mask_i),
        .valid_o      (mul_valid_o),
        .result_o     (mul_result_o)
    );

    // op_a is the dividend, op_b the divisor
    vint_div u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .go_i       (div_go),
        .signed_i   (div_signed),
        .want_rem_i (want_rem),
        .op_a_i     (op_a_i),
        .op_b_i     (op_b_i),
        .mask_i     (mask_i),
        .valid_o    (div_valid_o),
        .result_o   (div_result_o)
    );

endmodule
